/* vlog.f */
+incdir+common
common/matmul_pkg.sv
src/line_fifo.sv
src/afu_ctrl.sv
engine/dot_engine.sv
engine/line_packer.sv
src/matmul_afu.sv
verif/tb_matmul.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the output
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module tb_matmul -f vlog.f -Mdir obj_dir \
	&& ./obj_dir/Vtb_matmul | tee /dev/stderr | grep -xF '** PASS **' > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verif/tb_matmul.sv */
`timescale 1ns/1ns
`default_nettype none
`include "matmul_defines.svh"

module tb_matmul import matmul_pkg::*; ();

	localparam int lanes = `MM_LANES;
	localparam int max_m = 8;
	localparam int max_n = 16;
	localparam int max_k = 32;

	logic clk = 1'b0;
	logic reset;
	logic csr_wr;
	t_csr_addr csr_addr;
	t_dim csr_data;
	logic idle;
	logic a_push;
	logic b_push;
	t_line a_line;
	t_line b_line;
	logic a_full;
	logic b_full;
	logic out_pop;
	t_line out_line;
	logic out_empty;

	t_elem a_mat [max_m][max_k]; // Rows of A
	t_elem b_mat [max_n][max_k]; // Rows of transposed B
	t_line exp_q [$]; // Expected output lines in order
	logic [31:0] rng_state = 32'd21586;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_cnt = 0;
	int deadline = 100; // Covers reset and the idle checks

	matmul_afu u_dut (.*);

	always #2 clk = ~clk;

	// Watchdog, budget set per job
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > deadline) begin
			$display("timeout: job still running after %0d cycles", cycle_cnt);
			$display("** FAIL **");
			$finish;
		end
	end

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] rand_next();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic check_value(input string name, input logic [63:0] want, input logic [63:0] got);
		checks++;
		assert (got == want) else begin
			errors++;
			$display("error: %s expected %h got %h", name, want, got);
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err_start);
		end
	endtask

	task automatic csr_write(input t_csr_addr addr, input t_dim data);
		@(posedge clk);
		csr_wr <= 1'b1;
		csr_addr <= addr;
		csr_data <= data;
		@(posedge clk);
		csr_wr <= 1'b0;
	endtask

	task automatic wait_idle(input logic level);
		@(negedge clk);
		while (idle != level) @(negedge clk); // Watchdog ends a hang
	endtask

	// Output FIFO almost full stalls the engine, then the operand FIFOs fill
	task automatic wait_operands_full();
		@(negedge clk);
		while (!(a_full && b_full)) @(negedge clk); // Watchdog ends a hang
	endtask

	// Random operands and the wrapped dot products, row-major
	task automatic build_job(input int m_dim, input int n_dim, input int k_dim);
		logic [31:0] r;
		t_elem acc;
		t_line packed_exp;
		int idx;
		idx = 0;
		exp_q.delete();
		for (int i = 0; i < m_dim; i++) begin
			for (int e = 0; e < k_dim; e++) begin
				r = rand_next();
				a_mat[i][e] = r[15:0];
			end
		end
		for (int j = 0; j < n_dim; j++) begin
			for (int e = 0; e < k_dim; e++) begin
				r = rand_next();
				b_mat[j][e] = r[15:0];
			end
		end
		for (int i = 0; i < m_dim; i++) begin
			for (int j = 0; j < n_dim; j++) begin
				acc = '0;
				for (int e = 0; e < k_dim; e++) acc = acc + a_mat[i][e] * b_mat[j][e]; // Mod 2^16
				packed_exp[idx % lanes] = acc; // Lowest lane first
				idx++;
				if (idx % lanes == 0) exp_q.push_back(packed_exp);
			end
		end
	endtask

	// A and B lines of each (m, n) pair pushed in step
	task automatic push_operands(input int m_dim, input int n_dim, input int k_dim,
		input int max_gap);
		t_line la;
		t_line lb;
		int gap;
		for (int i = 0; i < m_dim; i++) begin
			for (int j = 0; j < n_dim; j++) begin
				for (int l = 0; l < k_dim / lanes; l++) begin
					for (int e = 0; e < lanes; e++) begin
						la[e] = a_mat[i][l * lanes + e];
						lb[e] = b_mat[j][l * lanes + e];
					end
					@(negedge clk);
					while (a_full || b_full) @(negedge clk); // Hold off on full
					@(posedge clk);
					a_push <= 1'b1;
					b_push <= 1'b1;
					a_line <= la;
					b_line <= lb;
					@(posedge clk);
					a_push <= 1'b0;
					b_push <= 1'b0;
					gap = (max_gap > 0) ? int'(rand_next() & 32'h7) % (max_gap + 1) : 0;
					repeat (gap) @(posedge clk);
				end
			end
		end
	endtask

	task automatic pop_results(input int max_stall);
		t_line want;
		int total;
		int got;
		int stall;
		total = exp_q.size();
		got = 0;
		while (got < total) begin
			@(negedge clk);
			if (!out_empty) begin
				stall = (max_stall > 0) ? int'(rand_next() & 32'hf) % (max_stall + 1) : 0;
				repeat (stall) @(negedge clk); // Back-pressure on the output FIFO
				@(posedge clk);
				out_pop <= 1'b1;
				@(posedge clk);
				out_pop <= 1'b0;
				@(negedge clk); // Read data one cycle after the pop
				want = exp_q.pop_front();
				check_value("out_line", want, out_line);
				got++;
			end
		end
	endtask

	// Ignored writes while the job runs
	task automatic disturb_job();
		repeat (5) @(posedge clk);
		checks++;
		assert (!idle) else begin
			errors++;
			$display("job ended before the mid-job writes were issued");
		end
		csr_write(CSR_M, t_dim'(3));
		csr_write(CSR_K, t_dim'(8));
		csr_write(CSR_RUN, t_dim'(1));
	endtask

	task automatic run_job(input int m_dim, input int n_dim, input int k_dim,
		input int push_gap, input int pop_stall, input bit disturb, input bit hold_pops);
		build_job(m_dim, n_dim, k_dim);
		deadline = cycle_cnt + 16 * (m_dim * n_dim * k_dim / lanes + exp_q.size()) + 200;
		csr_write(CSR_M, t_dim'(m_dim));
		csr_write(CSR_N, t_dim'(n_dim));
		csr_write(CSR_K, t_dim'(k_dim));
		csr_write(CSR_RUN, t_dim'(1));
		wait_idle(1'b0); // Operands only after the run pulse
		fork
			push_operands(m_dim, n_dim, k_dim, push_gap);
			begin
				if (hold_pops) wait_operands_full(); // No pops until the host is held off
				pop_results(pop_stall);
			end
			if (disturb) disturb_job();
		join
		wait_idle(1'b1);
		repeat (8) @(negedge clk);
		checks++;
		assert (out_empty && idle) else begin
			errors++;
			$display("output lines appeared beyond the expected count");
		end
		check_value("a_full", 64'(0), 64'(a_full));
		check_value("b_full", 64'(0), 64'(b_full));
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		int err_start;
		int m_dim;
		int n_dim;
		int k_dim;
		logic [31:0] r;
		reset <= 1'b1;
		csr_wr <= 1'b0;
		csr_addr <= CSR_RUN;
		csr_data <= '0;
		a_push <= 1'b0;
		b_push <= 1'b0;
		a_line <= '0;
		b_line <= '0;
		out_pop <= 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		err_start = errors;
		@(negedge clk);
		check_value("idle", 64'(1), 64'(idle));
		check_value("out_empty", 64'(1), 64'(out_empty));
		check_value("a_full", 64'(0), 64'(a_full));
		check_value("b_full", 64'(0), 64'(b_full));
		report_test("reset state", err_start);

		err_start = errors;
		run_job(1, 4, 4, 0, 0, 1'b0, 1'b0);
		report_test("single line M=1 N=4 K=4", err_start);

		err_start = errors;
		run_job(2, 2, 32, 0, 0, 1'b0, 1'b0); // Eight lines per row
		report_test("accumulate M=2 N=2 K=32", err_start);

		for (int t = 0; t < 5; t++) begin
			err_start = errors;
			r = rand_next();
			m_dim = 1 + int'(r[1:0]);
			n_dim = lanes * (1 + int'(r[2])); // Keeps M*N a multiple of LANES
			k_dim = lanes * (1 + int'(r[5:3]));
			run_job(m_dim, n_dim, k_dim, 3, 3, 1'b0, 1'b0);
			report_test($sformatf("random job %0d M=%0d N=%0d K=%0d", t, m_dim, n_dim, k_dim),
				err_start);
		end

		// 32 output lines, enough to fill the output FIFO and both operand FIFOs
		err_start = errors;
		run_job(8, 16, 4, 0, 2, 1'b0, 1'b1);
		report_test("back-pressure M=8 N=16 K=4", err_start);

		err_start = errors;
		run_job(2, 4, 16, 1, 2, 1'b1, 1'b0);
		report_test("writes ignored mid-job", err_start);

		$display("tests: %0d run, %0d failed; checks: %0d; errors: %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/matmul_afu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "matmul_defines.svh"

module matmul_afu import matmul_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	// Host register writes
	input  logic      csr_wr,
	input  t_csr_addr csr_addr,
	input  t_dim      csr_data,
	output logic      idle,
	// Operand lines, A and transposed B
	input  logic      a_push,
	input  t_line     a_line,
	output logic      a_full,
	input  logic      b_push,
	input  t_line     b_line,
	output logic      b_full,
	// Result lines
	input  logic      out_pop,
	output t_line     out_line,
	output logic      out_empty
);

	logic run;
	t_dim k_lines;
	logic operand_pop;
	t_line a_dout;
	t_line b_dout;
	logic a_empty;
	logic b_empty;
	logic out_afull;
	logic dot_valid;
	t_elem dot_value;
	logic line_valid;
	t_line packed_line;

	// ==============================
	// Controller and operand buffers
	// ==============================

	afu_ctrl u_ctrl (
		.clk(clk), .reset(reset),
		.csr_wr(csr_wr), .csr_addr(csr_addr), .csr_data(csr_data),
		.line_valid(line_valid), .out_empty(out_empty),
		.run(run), .k_lines(k_lines), .idle(idle)
	);

	line_fifo #(.afull_margin(0)) u_fifo_a (
		.clk(clk), .reset(reset), .push(a_push), .din(a_line), .pop(operand_pop),
		.dout(a_dout), .empty(a_empty), .full(a_full), .almost_full()
	);

	line_fifo #(.afull_margin(0)) u_fifo_b (
		.clk(clk), .reset(reset), .push(b_push), .din(b_line), .pop(operand_pop),
		.dout(b_dout), .empty(b_empty), .full(b_full), .almost_full()
	);

	// ==============================
	// Compute and result buffer
	// ==============================

	dot_engine u_engine (
		.clk(clk), .reset(reset), .run(run), .k_lines(k_lines),
		.a_dout(a_dout), .b_dout(b_dout), .a_empty(a_empty), .b_empty(b_empty),
		.out_afull(out_afull), .pop(operand_pop),
		.dot_valid(dot_valid), .dot_value(dot_value)
	);

	line_packer u_packer (
		.clk(clk), .reset(reset), .run(run), .dot_valid(dot_valid), .dot_value(dot_value),
		.line_valid(line_valid), .packed_line(packed_line)
	);

	// Margin covers the rows still in the adder tree
	line_fifo #(.afull_margin(`MM_AFULL_MARGIN)) u_fifo_out (
		.clk(clk), .reset(reset), .push(line_valid), .din(packed_line), .pop(out_pop),
		.dout(out_line), .empty(out_empty), .full(), .almost_full(out_afull)
	);

endmodule

`default_nettype wire

/* engine/line_packer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "matmul_defines.svh"

module line_packer import matmul_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  run, // Restart at lane 0
	input  logic  dot_valid,
	input  t_elem dot_value,
	output logic  line_valid, // Push strobe to the output FIFO
	output t_line packed_line
);

	localparam int lanes = `MM_LANES;
	localparam int pos_w = $clog2(lanes);

	logic [pos_w-1:0] pos; // Lane for the next result
	logic last_lane;

	assign last_lane = (pos == pos_w'(lanes - 1));

	always_ff @(posedge clk) begin
		if (reset || run) begin
			pos <= '0;
		end else if (dot_valid) begin
			pos <= last_lane ? '0 : pos + 1'b1;
		end
	end

	// Lowest lane first, row-major order from the engine
	always_ff @(posedge clk) begin
		if (dot_valid) begin
			packed_line[pos] <= dot_value;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			line_valid <= 1'b0;
		end else begin
			line_valid <= dot_valid && last_lane; // Line complete this edge
		end
	end

	// Previous job left no partial line behind
	a_start_aligned: assert property (@(posedge clk) disable iff (reset) run |-> pos == '0);

endmodule

`default_nettype wire

/* engine/dot_engine.sv */
`timescale 1ns/1ns
`default_nettype none
`include "matmul_defines.svh"

module dot_engine import matmul_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  run, // Clears the row position
	input  t_dim  k_lines, // Lines per row
	input  t_line a_dout,
	input  t_line b_dout,
	input  logic  a_empty,
	input  logic  b_empty,
	input  logic  out_afull,
	output logic  pop, // Shared by both operand FIFOs
	output logic  dot_valid,
	output t_elem dot_value
);

	localparam int lanes = `MM_LANES;
	localparam int half = lanes / 2;

	logic line_v; // Operand data on a_dout and b_dout
	t_dim line_cnt;
	logic first_line;
	logic last_line;
	logic row_end;
	t_elem prod [lanes];
	t_elem acc [lanes];
	t_elem sum1 [half];
	logic acc_v;
	logic sum1_v;

	// ==============================
	// Operand fetch
	// ==============================

	// Pairs only, and only with room for the rows in flight
	assign pop = !a_empty && !b_empty && !out_afull;

	always_ff @(posedge clk) begin
		if (reset) begin
			line_v <= 1'b0;
		end else begin
			line_v <= pop; // FIFO read data lands one cycle later
		end
	end

	always_ff @(posedge clk) begin
		if (reset || run) begin
			line_cnt <= '0;
		end else if (line_v) begin
			line_cnt <= last_line ? '0 : line_cnt + 1'b1;
		end
	end

	assign first_line = (line_cnt == '0);
	assign last_line = (line_cnt == k_lines - 1'b1);
	assign row_end = line_v && last_line;

	// ==============================
	// Multiply-accumulate per lane
	// ==============================

	always_comb begin
		for (int l = 0; l < lanes; l++) begin
			prod[l] = a_dout[l] * b_dout[l]; // Wraps to the lane width
		end
	end

	always_ff @(posedge clk) begin
		if (line_v) begin
			for (int l = 0; l < lanes; l++) begin
				acc[l] <= first_line ? prod[l] : acc[l] + prod[l]; // Load on a new row
			end
		end
	end

	// ==============================
	// Adder tree, two registered levels
	// ==============================

	always_ff @(posedge clk) begin
		for (int p = 0; p < half; p++) begin
			sum1[p] <= acc[2*p] + acc[2*p+1];
		end
		dot_value <= sum1[0] + sum1[1]; // Four lanes, two pair sums
	end

	// Valid follows the data through acc, level 1, level 2
	always_ff @(posedge clk) begin
		if (reset) begin
			acc_v <= 1'b0;
			sum1_v <= 1'b0;
			dot_valid <= 1'b0;
		end else begin
			acc_v <= row_end;
			sum1_v <= acc_v;
			dot_valid <= sum1_v;
		end
	end

	// A row length of zero would never close a row
	a_rows_closed: assert property (@(posedge clk) disable iff (reset)
		line_v |-> k_lines != '0);

endmodule

`default_nettype wire

/* src/afu_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "matmul_defines.svh"

module afu_ctrl import matmul_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      csr_wr, // One-cycle write strobe
	input  t_csr_addr csr_addr,
	input  t_dim      csr_data,
	input  logic      line_valid, // Output line pushed
	input  logic      out_empty,
	output logic      run, // One-cycle start pulse
	output t_dim      k_lines, // Lines per row
	output logic      idle
);

	localparam int lane_sh = $clog2(`MM_LANES);
	localparam int cnt_w = 2 * `MM_DIM_W; // Holds the full M*N product

	t_run_state state;
	t_dim m_dim;
	t_dim n_dim;
	t_dim k_dim;
	logic busy;
	logic run_req;
	logic [cnt_w-1:0] job_lines;
	logic [cnt_w-1:0] line_cnt;
	logic job_done;

	// ==============================
	// Register writes
	// ==============================

	// Configuration frozen from the run pulse until the job drains
	assign busy = (state == ST_RUN) || run;
	assign run_req = csr_wr && (csr_addr == CSR_RUN) && (csr_data != '0) && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			m_dim <= '0;
			n_dim <= '0;
			k_dim <= '0;
		end else if (csr_wr && !busy) begin
			case (csr_addr)
				CSR_M: m_dim <= csr_data;
				CSR_N: n_dim <= csr_data;
				CSR_K: k_dim <= csr_data;
				default: ; // CSR_RUN goes through run_req
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
		end else begin
			run <= run_req; // Pulse, busy blocks a repeat
		end
	end

	assign k_lines = k_dim >> lane_sh; // K is a multiple of LANES

	// ==============================
	// Job tracking
	// ==============================

	assign job_lines = (cnt_w'(m_dim) * cnt_w'(n_dim)) >> lane_sh;

	always_ff @(posedge clk) begin
		if (reset || run) begin
			line_cnt <= '0;
		end else if (line_valid) begin
			line_cnt <= line_cnt + 1'b1;
		end
	end

	// All lines produced and taken by the host
	assign job_done = (line_cnt == job_lines) && out_empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (run) state <= ST_RUN;
				ST_RUN:  if (job_done) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign idle = (state == ST_IDLE);

	// Packer output only while a job is active
	a_line_in_run: assert property (@(posedge clk) disable iff (reset)
		line_valid |-> state == ST_RUN);

endmodule

`default_nettype wire

/* src/line_fifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "matmul_defines.svh"

module line_fifo import matmul_pkg::*; #(
	parameter int afull_margin = 0 // Free entries left when almost_full rises
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  push,
	input  t_line din,
	input  logic  pop,
	output t_line dout, // Valid the cycle after pop
	output logic  empty,
	output logic  full,
	output logic  almost_full
);

	localparam int depth = `MM_FIFO_DEPTH;
	localparam int aw = $clog2(depth);

	t_line mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [aw:0] level; // One bit wider to reach depth

	// Storage and registered read port
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
		if (pop) begin
			dout <= mem[rd_ptr];
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: ; // Both or neither
			endcase
		end
	end

	assign empty = (level == '0);
	assign full = (level == (aw + 1)'(depth));
	assign almost_full = (level >= (aw + 1)'(depth - afull_margin));

	a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

`default_nettype wire

/* common/matmul_pkg.sv */
`default_nettype none
`include "matmul_defines.svh"

package matmul_pkg;

	// ==============================
	// Data types
	// ==============================

	typedef logic signed [`MM_ELEM_W-1:0] t_elem; // One lane value
	typedef t_elem [`MM_LANES-1:0] t_line; // Lane 0 sits in the low bits
	typedef logic [`MM_DIM_W-1:0] t_dim; // Dimension or count

	// ==============================
	// Control encodings
	// ==============================

	// Host register map
	typedef enum logic [1:0] {
		CSR_RUN = 2'd0, // Nonzero write starts a job
		CSR_M   = 2'd1, // Rows of A
		CSR_N   = 2'd2, // Rows of transposed B
		CSR_K   = 2'd3 // Dot product length
	} t_csr_addr;

	// Controller states
	typedef enum logic [0:0] {
		ST_IDLE,
		ST_RUN
	} t_run_state;

endpackage

`default_nettype wire

/* common/matmul_defines.svh */
`ifndef MATMUL_DEFINES_SVH
`define MATMUL_DEFINES_SVH

// ==============================
// Datapath sizes
// ==============================

// Elements per line, lane 0 in the low bits
`define MM_LANES 4

// Signed lane width, products and sums wrap at this width
`define MM_ELEM_W 16

// ==============================
// Buffering and counters
// ==============================

`define MM_FIFO_DEPTH 16 // Entries per line FIFO, power of two
`define MM_DIM_W 16 // M, N, K and line counters

// Free output entries kept for rows still in the adder tree
`define MM_AFULL_MARGIN 2

`endif
